// ==== assembler_pkg.sv ====
// assembler package
// sizes shared by the channel-to-ring assembler: word width,
// channel and lane counts, pointer widths and the wide-word width

package assembler_pkg;

   // width of one narrow channel word
   localparam int WORD_W = 16;

   // number of narrow input channels
   localparam int NUM_IN = 4;

   // number of output lanes, one two-entry FIFO each
   localparam int NUM_OUT = 3;

   // index width for the input channels and the top-channel input
   localparam int IN_PTR_W = $clog2(NUM_IN);

   // index width for the lanes and the top-lane input
   localparam int OUT_PTR_W = $clog2(NUM_OUT);

   // assembled word, lane k sits at bits k*WORD_W upward
   localparam int WIDE_W = NUM_OUT * WORD_W;

endpackage

// ==== lane_two_fifo.sv ====
// lane two-entry FIFO
// two-slot storage with ready on the enqueue side and valid/yumi
// on the dequeue side, enqueue and dequeue may share a cycle

`timescale 1ns/1ps

module lane_two_fifo
   (
      input  logic                               clk_i,
      input  logic                               rst_n_i,

      // enqueue side
      input  logic                               v_i,
      input  logic [assembler_pkg::WORD_W-1:0]   data_i,
      output logic                               ready_o,

      // dequeue side
      output logic                               v_o,
      output logic [assembler_pkg::WORD_W-1:0]   data_o,
      input  logic                               yumi_i
   );

   // storage slots, payload only
   logic [assembler_pkg::WORD_W-1:0] mem_r [2];

   logic wptr_r;
   logic rptr_r;
   logic full_r;
   logic empty_r;

   logic enq;
   logic deq;

   // an enqueue is only taken while a slot is free
   assign enq = v_i & ~full_r;

   // the consumer only yumis a valid head
   assign deq = yumi_i & ~empty_r;

   assign ready_o = ~full_r;
   assign v_o     = ~empty_r;
   assign data_o  = mem_r[rptr_r];

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_r[wptr_r] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_r  <= 1'b0;
         rptr_r  <= 1'b0;
         full_r  <= 1'b0;
         empty_r <= 1'b1;
      end
      else
      begin
         if (enq)
         begin
            wptr_r <= ~wptr_r;
         end
         if (deq)
         begin
            rptr_r <= ~rptr_r;
         end

         // occupancy only moves when exactly one side acts
         if (enq && !deq)
         begin
            empty_r <= 1'b0;
            // second word lands when the write pointer catches the read pointer
            full_r  <= (~wptr_r == rptr_r);
         end
         else if (deq && !enq)
         begin
            full_r  <= 1'b0;
            // last word leaves when the read pointer catches the write pointer
            empty_r <= (~rptr_r == wptr_r);
         end
      end
   end

endmodule

// ==== rr_channel_to_lane.sv ====
// round-robin channel to lane router
// takes words from the input channels in strict order and deals
// them in order into the lanes, one word per cycle

`timescale 1ns/1ps

module rr_channel_to_lane
   (
      input  logic                                  clk_i,
      input  logic                                  rst_n_i,

      // narrow input channels, valid/yumi
      input  logic [assembler_pkg::NUM_IN-1:0]      valid_i,
      input  logic [assembler_pkg::WORD_W-1:0]      data_i [assembler_pkg::NUM_IN],
      output logic [assembler_pkg::NUM_IN-1:0]      yumi_o,

      // highest active channel and lane, stable outside reset
      input  logic [assembler_pkg::IN_PTR_W-1:0]    in_top_channel_i,
      input  logic [assembler_pkg::OUT_PTR_W-1:0]   out_top_lane_i,

      // lane enqueue side, data bus shared by all lanes
      output logic [assembler_pkg::NUM_OUT-1:0]     lane_v_o,
      output logic [assembler_pkg::WORD_W-1:0]      lane_data_o,
      input  logic [assembler_pkg::NUM_OUT-1:0]     lane_ready_i
   );

   // channel currently owed a turn
   logic [assembler_pkg::IN_PTR_W-1:0]  in_ptr_r;
   logic [assembler_pkg::IN_PTR_W-1:0]  in_ptr_n;

   // lane that receives the next word
   logic [assembler_pkg::OUT_PTR_W-1:0] out_ptr_r;
   logic [assembler_pkg::OUT_PTR_W-1:0] out_ptr_n;

   logic                                sel_valid;
   logic                                sel_ready;
   logic                                xfer;

   // look up the pointed channel and the pointed lane
   always_comb
   begin
      sel_valid   = 1'b0;
      lane_data_o = '0;
      for (int i = 0; i < assembler_pkg::NUM_IN; i++)
      begin
         if (in_ptr_r == i[assembler_pkg::IN_PTR_W-1:0])
         begin
            sel_valid   = valid_i[i];
            lane_data_o = data_i[i];
         end
      end
   end

   always_comb
   begin
      sel_ready = 1'b0;
      for (int k = 0; k < assembler_pkg::NUM_OUT; k++)
      begin
         if (out_ptr_r == k[assembler_pkg::OUT_PTR_W-1:0])
         begin
            sel_ready = lane_ready_i[k];
         end
      end
   end

   // a word moves only when both ends are willing,
   // otherwise we wait on this channel rather than skip it
   assign xfer = sel_valid & sel_ready;

   // yumi goes to the pointed channel alone
   always_comb
   begin
      yumi_o = '0;
      for (int i = 0; i < assembler_pkg::NUM_IN; i++)
      begin
         if (in_ptr_r == i[assembler_pkg::IN_PTR_W-1:0])
         begin
            yumi_o[i] = xfer;
         end
      end
   end

   // enqueue goes to the pointed lane alone
   always_comb
   begin
      lane_v_o = '0;
      for (int k = 0; k < assembler_pkg::NUM_OUT; k++)
      begin
         if (out_ptr_r == k[assembler_pkg::OUT_PTR_W-1:0])
         begin
            lane_v_o[k] = xfer;
         end
      end
   end

   // advance both pointers on a transfer, wrapping at the top values
   always_comb
   begin
      in_ptr_n  = in_ptr_r;
      out_ptr_n = out_ptr_r;
      if (xfer)
      begin
         if (in_ptr_r >= in_top_channel_i)
         begin
            in_ptr_n = '0;
         end
         else
         begin
            in_ptr_n = in_ptr_r + 1'b1;
         end

         if (out_ptr_r >= out_top_lane_i)
         begin
            out_ptr_n = '0;
         end
         else
         begin
            out_ptr_n = out_ptr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         in_ptr_r  <= '0;
         out_ptr_r <= '0;
      end
      else
      begin
         in_ptr_r  <= in_ptr_n;
         out_ptr_r <= out_ptr_n;
      end
   end

endmodule

// ==== assembler_in.sv ====
// assembler in, channels to ring
// gates the channels with calibration, routes words round-robin into
// the lane FIFOs and offers one wide word once every active lane holds one

`timescale 1ns/1ps

module assembler_in
   (
      input  logic                                  clk_i,
      input  logic                                  rst_n_i,
      input  logic                                  calibration_done_i,

      // narrow input channels
      input  logic [assembler_pkg::NUM_IN-1:0]      valid_i,
      input  logic [assembler_pkg::WORD_W-1:0]      data_i [assembler_pkg::NUM_IN],
      output logic [assembler_pkg::NUM_IN-1:0]      yumi_o,

      // e.g. three active channels means in_top_channel_i = 2
      input  logic [assembler_pkg::IN_PTR_W-1:0]    in_top_channel_i,
      input  logic [assembler_pkg::OUT_PTR_W-1:0]   out_top_lane_i,

      // wide ring-side word
      output logic                                  valid_o,
      output logic [assembler_pkg::WIDE_W-1:0]      data_o,
      input  logic                                  yumi_i
   );

   logic [assembler_pkg::NUM_IN-1:0]  gated_valid;

   logic [assembler_pkg::NUM_OUT-1:0] lane_enq;
   logic [assembler_pkg::NUM_OUT-1:0] lane_ready;
   logic [assembler_pkg::NUM_OUT-1:0] lane_v;
   logic [assembler_pkg::NUM_OUT-1:0] lane_active;
   logic [assembler_pkg::WORD_W-1:0]  lane_wdata;
   logic [assembler_pkg::WORD_W-1:0]  lane_rdata [assembler_pkg::NUM_OUT];

   // nothing is accepted before calibration finishes
   assign gated_valid = valid_i & {assembler_pkg::NUM_IN{calibration_done_i}};

   rr_channel_to_lane router
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .valid_i          (gated_valid),
      .data_i           (data_i),
      .yumi_o           (yumi_o),
      .in_top_channel_i (in_top_channel_i),
      .out_top_lane_i   (out_top_lane_i),
      .lane_v_o         (lane_enq),
      .lane_data_o      (lane_wdata),
      .lane_ready_i     (lane_ready)
   );

   // lanes up to and including the top lane take part
   always_comb
   begin
      for (int k = 0; k < assembler_pkg::NUM_OUT; k++)
      begin
         lane_active[k] = (k[assembler_pkg::OUT_PTR_W-1:0] <= out_top_lane_i);
      end
   end

   for (genvar k = 0; k < assembler_pkg::NUM_OUT; k++)
   begin : g_lane
      lane_two_fifo lane
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (lane_enq[k]),
         .data_i  (lane_wdata),
         .ready_o (lane_ready[k]),
         .v_o     (lane_v[k]),
         .data_o  (lane_rdata[k]),
         // all active lanes leave together
         .yumi_i  (yumi_i & lane_active[k])
      );

      // inactive lanes read as zero in the wide word
      assign data_o[k*assembler_pkg::WORD_W +: assembler_pkg::WORD_W] =
         lane_rdata[k] & {assembler_pkg::WORD_W{lane_active[k]}};
   end

   // inactive lanes count as ready so only the active ones decide
   assign valid_o = (&(lane_v | ~lane_active)) & calibration_done_i;

endmodule

// ==== assembler_checker.sv ====
// assembler checker
// watches the channel and ring handshakes of the assembler and
// compares each wide word taken against the expected sequence

`timescale 1ns/1ps

module assembler_checker
   (
      input  logic                                  clk_i,
      input  logic                                  rst_n_i,
      input  logic                                  calibration_done_i,
      input  logic [assembler_pkg::NUM_IN-1:0]      ch_yumi_i,
      input  logic [assembler_pkg::IN_PTR_W-1:0]    in_top_i,
      input  logic [assembler_pkg::OUT_PTR_W-1:0]   out_top_i,
      input  logic                                  ring_valid_i,
      input  logic [assembler_pkg::WIDE_W-1:0]      ring_data_i,
      input  logic                                  ring_yumi_i
   );

   logic [assembler_pkg::WIDE_W-1:0] exp_q [$];
   logic [assembler_pkg::WIDE_W-1:0] exp_word;
   logic [127:0]                     test_name;
   logic                             valid_seen;
   int                               error_count = 0;
   int                               test_errors = 0;
   int                               tests_run = 0;
   int                               tests_failed = 0;
   int                               occupancy = 0;
   int                               lanes;

   task automatic start_test(input logic [127:0] name);
      test_name   = name;
      test_errors = 0;
      occupancy   = 0;
      exp_q.delete();
   endtask

   task automatic push_expected(input logic [assembler_pkg::WIDE_W-1:0] w);
      exp_q.push_back(w);
   endtask

   function automatic int pending();
      return exp_q.size();
   endfunction

   task automatic count_error();
      error_count++;
      test_errors++;
   endtask

   task automatic end_test();
      if (exp_q.size() != 0)
      begin
         $display("test %0s ended with %0d expected wide words never delivered",
                  test_name, exp_q.size());
         count_error();
      end
      tests_run++;
      if (test_errors == 0)
      begin
         $display("test %0s passed", test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %0s failed with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic report_counts();
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, error_count);
   endtask

   // sample half a cycle after the stimulus settles
   always @(negedge clk_i)
   begin
      if (!rst_n_i)
      begin
         valid_seen = 1'b0;
      end
      else
      begin
         lanes = int'(out_top_i) + 1;
         if (!calibration_done_i && (ch_yumi_i != '0 || ring_valid_i))
         begin
            $display("traffic seen at %0d ns while calibration is still low", $time);
            count_error();
         end
         if ((ch_yumi_i >> (int'(in_top_i) + 1)) != '0)
         begin
            $display("a channel above the top channel got yumi at %0d ns", $time);
            count_error();
         end
         if (ring_valid_i && !valid_seen && exp_q.size() == 0)
         begin
            $display("valid_o rose at %0d ns with no wide word expected", $time);
            count_error();
         end
         if (ring_valid_i && ring_yumi_i)
         begin
            if (exp_q.size() != 0)
            begin
               exp_word = exp_q.pop_front();
               if (ring_data_i !== exp_word)
               begin
                  $display("** Error at %0d ns: wide word expected %h, got %h",
                           $time, exp_word, ring_data_i);
                  count_error();
               end
            end
            else if (valid_seen)
            begin
               $display("a wide word beyond the expected ones was taken at %0d ns", $time);
               count_error();
            end
         end
         // the lanes hold at most two words each
         occupancy = occupancy + $countones(ch_yumi_i);
         if (ring_valid_i && ring_yumi_i)
         begin
            occupancy = occupancy - lanes;
         end
         if (occupancy > 2 * lanes)
         begin
            $display("a word was accepted at %0d ns while every lane was full", $time);
            count_error();
         end
         valid_seen = ring_valid_i;
      end
   end

endmodule

// ==== tb_assembler_in.sv ====
// assembler testbench
// runs the golden tests against the channel-to-ring assembler,
// drives the channels with random idle gaps and bounds the run time

`timescale 1ns/1ps

module tb_assembler_in;

   logic                                  clk;
   logic                                  rst_n;
   logic                                  calibration_done;
   logic [assembler_pkg::NUM_IN-1:0]      ch_valid;
   logic [assembler_pkg::WORD_W-1:0]      ch_data [assembler_pkg::NUM_IN];
   logic [assembler_pkg::NUM_IN-1:0]      ch_yumi;
   logic [assembler_pkg::IN_PTR_W-1:0]    in_top;
   logic [assembler_pkg::OUT_PTR_W-1:0]   out_top;
   logic                                  ring_valid;
   logic [assembler_pkg::WIDE_W-1:0]      ring_data;
   logic                                  ring_yumi;

   // golden tests, channel words and wide words kept in flat memories
   logic [127:0]                          name_a [16];
   logic [assembler_pkg::IN_PTR_W-1:0]    in_top_a [16];
   logic [assembler_pkg::OUT_PTR_W-1:0]   out_top_a [16];
   int                                    cal_low_a [16];
   int                                    bp_a [16];
   int                                    gap_a [16];
   int                                    word_base [16][assembler_pkg::NUM_IN];
   int                                    word_cnt [16][assembler_pkg::NUM_IN];
   int                                    exp_base [16];
   int                                    exp_cnt [16];
   logic [assembler_pkg::WORD_W-1:0]      word_mem [1024];
   logic [assembler_pkg::WIDE_W-1:0]      exp_mem [256];
   int                                    num_tests = 0;
   int                                    num_words = 0;
   int                                    num_exp = 0;
   int                                    total_words = 0;
   int                                    cycle_count = 0;
   int                                    cycle_limit = 0;
   int                                    idx [assembler_pkg::NUM_IN];
   logic [assembler_pkg::NUM_IN-1:0]      taken;

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   assembler_in DUT
   (
      .clk_i              (clk),
      .rst_n_i            (rst_n),
      .calibration_done_i (calibration_done),
      .valid_i            (ch_valid),
      .data_i             (ch_data),
      .yumi_o             (ch_yumi),
      .in_top_channel_i   (in_top),
      .out_top_lane_i     (out_top),
      .valid_o            (ring_valid),
      .data_o             (ring_data),
      .yumi_i             (ring_yumi)
   );

   assembler_checker chk
   (
      .clk_i              (clk),
      .rst_n_i            (rst_n),
      .calibration_done_i (calibration_done),
      .ch_yumi_i          (ch_yumi),
      .in_top_i           (in_top),
      .out_top_i          (out_top),
      .ring_valid_i       (ring_valid),
      .ring_data_i        (ring_data),
      .ring_yumi_i        (ring_yumi)
   );

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
      begin
         $display("timeout after %0d cycles, wide words stopped arriving", cycle_count);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic load_golden(output bit ok);
      int                               fd;
      int                               r;
      int                               c;
      int                               n;
      logic [127:0]                     tok;
      logic [8*120-1:0]                 line;
      logic [assembler_pkg::WORD_W-1:0] w;
      logic [assembler_pkg::WIDE_W-1:0] wide;
      fd = $fopen("assembler_golden.txt", "r");
      ok = (fd != 0);
      while (ok && $fscanf(fd, "%s", tok) == 1)
      begin
         if (tok == "#")
         begin
            r = $fgets(line, fd);
         end
         else if (tok == "test")
         begin
            r = $fscanf(fd, "%s %d %d %d %d %d", name_a[num_tests], in_top_a[num_tests],
                        out_top_a[num_tests], cal_low_a[num_tests], bp_a[num_tests],
                        gap_a[num_tests]);
            num_tests++;
         end
         else if (tok == "ch")
         begin
            r = $fscanf(fd, "%d %d", c, n);
            word_base[num_tests-1][c] = num_words;
            word_cnt[num_tests-1][c]  = n;
            total_words += n;
            repeat (n)
            begin
               r = $fscanf(fd, "%h", w);
               word_mem[num_words] = w;
               num_words++;
            end
         end
         else if (tok == "exp")
         begin
            r = $fscanf(fd, "%d", n);
            exp_base[num_tests-1] = num_exp;
            exp_cnt[num_tests-1]  = n;
            total_words += n;
            repeat (n)
            begin
               r = $fscanf(fd, "%h", wide);
               exp_mem[num_exp] = wide;
               num_exp++;
            end
         end
      end
      if (ok)
      begin
         $fclose(fd);
      end
   endtask

   // top inputs only change while reset is held
   task automatic apply_reset(input int t);
      rst_n            = 1'b0;
      calibration_done = 1'b0;
      ch_valid         = '0;
      ring_yumi        = 1'b0;
      in_top           = in_top_a[t];
      out_top          = out_top_a[t];
      repeat (10)
      begin
         @(posedge clk);
      end
      #1;
      rst_n = 1'b1;
   endtask

   task automatic run_test(input int t);
      int cyc;
      chk.start_test(name_a[t]);
      for (int e = 0; e < exp_cnt[t]; e++)
      begin
         chk.push_expected(exp_mem[exp_base[t] + e]);
      end
      cyc   = 0;
      taken = '0;
      for (int c = 0; c < assembler_pkg::NUM_IN; c++)
      begin
         idx[c] = 0;
      end
      while (chk.pending() > 0)
      begin
         cyc++;
         calibration_done = (cyc > cal_low_a[t]);
         for (int c = 0; c < assembler_pkg::NUM_IN; c++)
         begin
            // a taken word leaves and the next one may follow at once
            if (taken[c])
            begin
               ch_valid[c] = 1'b0;
               idx[c]++;
            end
            if (!ch_valid[c] && idx[c] < word_cnt[t][c] && ($urandom % 100) >= gap_a[t])
            begin
               ch_valid[c] = 1'b1;
               ch_data[c]  = word_mem[word_base[t][c] + idx[c]];
            end
         end
         // ring side holds off during the back-pressure phase
         ring_yumi = ring_valid && (cyc > cal_low_a[t] + bp_a[t]);
         @(negedge clk);
         taken = ch_yumi & ch_valid;
         @(posedge clk);
         #1;
      end
      // quiet cycles to catch a stray wide word
      ch_valid = '0;
      repeat (4)
      begin
         ring_yumi = ring_valid;
         @(posedge clk);
         #1;
      end
      chk.end_test();
   endtask

   initial
   begin
      bit ok;
      int seed;
      seed             = 32'h036882b3;
      void'($urandom(seed));
      rst_n            = 1'b0;
      calibration_done = 1'b0;
      ch_valid         = '0;
      ring_yumi        = 1'b0;
      in_top           = '0;
      out_top          = '0;
      for (int c = 0; c < assembler_pkg::NUM_IN; c++)
      begin
         ch_data[c] = '0;
      end
      load_golden(ok);
      if (!ok)
      begin
         $display("could not open assembler_golden.txt for reading");
         $display("ERRORS FOUND");
      end
      else
      begin
         cycle_limit = 40 * total_words + 20 * num_tests;
         for (int t = 0; t < num_tests; t++)
         begin
            apply_reset(t);
            run_test(t);
         end
         chk.report_counts();
         if (chk.error_count == 0)
         begin
            $display("NO ERRORS");
         end
         else
         begin
            $display("ERRORS FOUND");
         end
      end
      $finish;
   end

endmodule

// ==== assembler_golden.txt ====
# test <name> <in_top> <out_top> <calibration low cycles> <back-pressure cycles> <idle gap %>
# ch <channel> <count> <words in order>  and  exp <count> <wide words, lane 0 in low bits>
test full 3 2 0 0 20
ch 0 3 0a01 0a02 0a03
ch 1 3 1a01 1a02 1a03
ch 2 3 2a01 2a02 2a03
ch 3 3 3a01 3a02 3a03
exp 4 2a011a010a01 1a020a023a01 0a033a022a02 3a032a031a03
test two_channels 1 2 0 0 20
ch 0 3 0b01 0b02 0b03
ch 1 3 1b01 1b02 1b03
ch 2 1 2b01
ch 3 1 3b01
exp 2 0b021b010b01 1b030b031b02
test two_lanes 3 1 0 0 20
ch 0 2 0c01 0c02
ch 1 2 1c01 1c02
ch 2 2 2c01 2c02
ch 3 2 3c01 3c02
exp 4 00001c010c01 00003c012c01 00001c020c02 00003c022c02
test calibration_low 3 2 25 0 20
ch 0 3 0d01 0d02 0d03
ch 1 3 1d01 1d02 1d03
ch 2 3 2d01 2d02 2d03
ch 3 3 3d01 3d02 3d03
exp 4 2d011d010d01 1d020d023d01 0d033d022d02 3d032d031d03
test back_pressure 3 2 0 40 10
ch 0 3 0e01 0e02 0e03
ch 1 3 1e01 1e02 1e03
ch 2 3 2e01 2e02 2e03
ch 3 3 3e01 3e02 3e03
exp 4 2e011e010e01 1e020e023e01 0e033e022e02 3e032e031e03
test random_gaps 3 2 0 0 70
ch 0 3 0a01 0a02 0a03
ch 1 3 1a01 1a02 1a03
ch 2 3 2a01 2a02 2a03
ch 3 3 3a01 3a02 3a03
exp 4 2a011a010a01 1a020a023a01 0a033a022a02 3a032a031a03

// ==== assembler_in.f ====
assembler_pkg.sv
lane_two_fifo.sv
rr_channel_to_lane.sv
assembler_in.sv
assembler_checker.sv
tb_assembler_in.sv

// ==== Bender.yml ====
package:
  name: assembler_in

sources:
  - assembler_pkg.sv
  - lane_two_fifo.sv
  - rr_channel_to_lane.sv
  - assembler_in.sv
  - target: test
    files:
      - assembler_checker.sv
      - tb_assembler_in.sv
